// ==== src/spi_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// SPI master shared types: byte and command formats, frame states
// and chip-select timing constants
//////////////////////////////////////////////////////////////////////
package spi_pkg;

  //////////////////////////////////////////////////////////////////////
  // Data and command widths
  //////////////////////////////////////////////////////////////////////
  localparam int BYTE_W   = 8;          // Bits per SPI byte
  localparam int TX_LEN_W = 4;          // TX byte count, 1..15
  localparam int RX_LEN_W = 4;          // RX byte count, 0..15
  localparam int WAIT_W   = 2;          // Wait periods between TX and RX

  typedef logic [BYTE_W-1:0] byte_t;

  // One bus frame request, latched whole by the sequencer
  typedef struct packed {
    logic [TX_LEN_W-1:0] tx_len;
    logic [WAIT_W-1:0]   wait_cyc;
    logic [RX_LEN_W-1:0] rx_len;
  } spi_cmd_t;

  //////////////////////////////////////////////////////////////////////
  // Frame FSM
  //////////////////////////////////////////////////////////////////////
  typedef enum logic [2:0] {
    IDLE,
    START_D,                            // CSn high settle
    START_S,                            // CSn low setup, SCK idle
    TX,
    WAIT,
    RX,
    STOP_S,                             // CSn low hold
    STOP_D                              // CSn high before idle
  } spi_state_t;

  // SCK periods spent in each chip-select phase
  localparam int SS_PERIODS = 4;

  // Longest phase is a full 15-byte shift
  localparam int MAX_LEN   = (1 << TX_LEN_W) - 1;
  localparam int BIT_CNT_W = $clog2(BYTE_W * MAX_LEN);

endpackage : spi_pkg

// ==== src/spi_phase_gen.sv ====
//////////////////////////////////////////////////////////////////////
// SCK phase counter with rise and fall enables
//////////////////////////////////////////////////////////////////////
module spi_phase_gen #(
  parameter int RATIO = 8               // System clocks per SCK period, even, >= 4
) (
  input  logic i_ext_spi_clk_x,
  input  logic i_srst,
  output logic o_rise_en,               // One cycle at count 0
  output logic o_fall_en,               // One cycle at count RATIO/2
  output logic o_sck_level              // Free-running 50% SCK
);

  localparam int CNT_W = $clog2(RATIO);
  localparam int HALF  = RATIO / 2;

  logic [CNT_W-1:0] phase_q;

  // Free-running, period of RATIO system clocks
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      phase_q <= '0;
    end else if (phase_q == CNT_W'(RATIO - 1)) begin
      phase_q <= '0;
    end else begin
      phase_q <= phase_q + 1'b1;
    end
  end

  // High half first, so the rising edge lines up with count 0
  assign o_sck_level = (phase_q < CNT_W'(HALF));

  assign o_rise_en = (phase_q == '0);
  assign o_fall_en = (phase_q == CNT_W'(HALF));

endmodule : spi_phase_gen

// ==== src/spi_byte_fifo.sv ====
//////////////////////////////////////////////////////////////////////
// Synchronous first-word-fall-through byte FIFO
//////////////////////////////////////////////////////////////////////
module spi_byte_fifo #(
  parameter int DEPTH = 16              // Entries, any value >= 2
) (
  input  logic           i_ext_spi_clk_x,
  input  logic           i_srst,
  // Write side
  input  logic           i_wr_valid,
  input  spi_pkg::byte_t i_wr_data,
  output logic           o_wr_ready,
  // Read side, head is always visible
  input  logic           i_rd_ready,
  output logic           o_rd_valid,
  output spi_pkg::byte_t o_rd_data
);
  import spi_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  byte_t            mem [DEPTH];        // Storage
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;            // Occupancy

  logic wr_en;
  logic rd_en;

  assign wr_en = i_wr_valid && o_wr_ready;  // Write into a full FIFO is lost
  assign rd_en = i_rd_ready && o_rd_valid;

  always_ff @(posedge i_ext_spi_clk_x) begin
    if (wr_en) begin
      mem[wr_ptr_q] <= i_wr_data;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Pointers wrap at DEPTH, count tracks both sides
  ////////////////////////////////////////////////////////////////////
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (wr_en && !rd_en) begin
        count_q <= count_q + 1'b1;
      end else if (rd_en && !wr_en) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  assign o_wr_ready = (count_q != CNT_W'(DEPTH));
  assign o_rd_valid = (count_q != '0);
  assign o_rd_data  = mem[rd_ptr_q];    // Head falls through

endmodule : spi_byte_fifo

// ==== src/spi_cmd_capture.sv ====
//////////////////////////////////////////////////////////////////////
// Single-entry command holding register between the system side
// and the bus sequencer
//////////////////////////////////////////////////////////////////////
module spi_cmd_capture (
  input  logic              i_ext_spi_clk_x,
  input  logic              i_srst,
  // System command handshake
  input  logic              i_cmd_valid,
  input  spi_pkg::spi_cmd_t i_cmd,
  output logic              o_cmd_ready,
  // Offer to the sequencer
  input  logic              i_seq_ready,
  output logic              o_seq_valid,
  output spi_pkg::spi_cmd_t o_seq_cmd
);
  import spi_pkg::*;

  logic     full_q;                     // Entry holds a command
  spi_cmd_t cmd_q;                      // Latched lengths

  logic cmd_take;                       // System side transfer
  logic seq_take;                       // Sequencer accepts the entry

  assign cmd_take = i_cmd_valid && o_cmd_ready;
  assign seq_take = o_seq_valid && i_seq_ready;

  // Occupancy flag
  // Fill and drain never coincide, ready needs an empty entry
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      full_q <= 1'b0;
    end else if (cmd_take) begin
      full_q <= 1'b1;
    end else if (seq_take) begin
      full_q <= 1'b0;
    end
  end

  // Lengths stay put until the sequencer has them
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (cmd_take) begin
      cmd_q <= i_cmd;
    end
  end

  assign o_cmd_ready = !full_q;
  assign o_seq_valid = full_q;
  assign o_seq_cmd   = cmd_q;

endmodule : spi_cmd_capture

// ==== src/spi_bus_sequencer.sv ====
//////////////////////////////////////////////////////////////////////
// SPI Mode 0 frame FSM with chip select timing, SCK gating, COPI shift
// and TX FIFO pops
//////////////////////////////////////////////////////////////////////
module spi_bus_sequencer (
  input  logic                i_ext_spi_clk_x,
  input  logic                i_srst,
  // Phase enables
  input  logic                i_rise_en,
  input  logic                i_fall_en,
  input  logic                i_sck_level,
  // Command from capture
  input  logic                i_cmd_valid,
  input  spi_pkg::spi_cmd_t   i_cmd,
  output logic                o_cmd_ready,
  // TX FIFO head
  input  logic                i_tx_valid,
  input  spi_pkg::byte_t      i_tx_data,
  output logic                o_tx_pop,
  // Status and bus
  output spi_pkg::spi_state_t o_state,
  output logic                o_sck,
  output logic                o_csn,
  output logic                o_copi
);
  import spi_pkg::*;

  localparam logic [BIT_CNT_W-1:0] SS_LAST = BIT_CNT_W'(SS_PERIODS - 1);

  spi_state_t           state_q;
  spi_state_t           state_d;
  logic [BIT_CNT_W-1:0] cnt_q;          // Periods spent in current state
  spi_cmd_t             cmd_q;          // Frame lengths

  logic [BIT_CNT_W-1:0] tx_last;
  logic [BIT_CNT_W-1:0] wait_last;
  logic [BIT_CNT_W-1:0] rx_last;
  spi_state_t           after_tx;
  spi_state_t           after_wait;

  // TX byte committed at its first rising edge
  byte_t byte_q;
  logic  byte_vld_q;
  logic  byte_lock_q;
  byte_t cur_data;
  logic  cur_valid;
  logic  last_bit;                      // Final bit of a byte

  assign tx_last   = BIT_CNT_W'(cmd_q.tx_len * BYTE_W) - 1'b1;
  assign wait_last = BIT_CNT_W'(cmd_q.wait_cyc) - 1'b1;
  assign rx_last   = BIT_CNT_W'(cmd_q.rx_len * BYTE_W) - 1'b1;

  // Empty WAIT and RX phases are skipped
  assign after_wait = (cmd_q.rx_len != '0) ? RX : STOP_S;
  assign after_tx   = (cmd_q.wait_cyc != '0) ? WAIT : after_wait;

  //////////////////////////////////////////////////////////////////////
  // Next state evaluated once per SCK period
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (i_cmd_valid)        state_d = START_D;
      START_D: if (cnt_q == SS_LAST)   state_d = START_S;
      START_S: if (cnt_q == SS_LAST)   state_d = TX;
      TX:      if (cnt_q == tx_last)   state_d = after_tx;
      WAIT:    if (cnt_q == wait_last) state_d = after_wait;
      RX:      if (cnt_q == rx_last)   state_d = STOP_S;
      STOP_S:  if (cnt_q == SS_LAST)   state_d = STOP_D;
      STOP_D:  if (cnt_q == SS_LAST)   state_d = IDLE;
    endcase
  end

  // State and counter move only on the falling SCK enable
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else if (i_fall_en) begin
      state_q <= state_d;
      if ((state_d != state_q) || (state_q == IDLE)) begin
        cnt_q <= '0;                    // Fresh count per phase
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // Command taken only from IDLE at a fall enable
  assign o_cmd_ready = (state_q == IDLE) && i_fall_en;

  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_cmd_valid && o_cmd_ready) begin
      cmd_q <= i_cmd;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // TX byte hold
  //////////////////////////////////////////////////////////////////////
  // First bit period comes straight from the FIFO head; a byte landing in
  // an empty FIFO mid-byte must not change COPI or get popped unsent
  assign last_bit = (cnt_q[2:0] == 3'd7);

  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      byte_lock_q <= 1'b0;
      byte_vld_q  <= 1'b0;
    end else if (i_rise_en && (state_q == TX) && (cnt_q[2:0] == 3'd0)) begin
      byte_lock_q <= 1'b1;
      byte_vld_q  <= i_tx_valid;
    end else if (i_fall_en && (last_bit || (state_q != TX))) begin
      byte_lock_q <= 1'b0;              // Next byte starts from the head
    end
  end

  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_rise_en && (state_q == TX) && (cnt_q[2:0] == 3'd0)) begin
      byte_q <= i_tx_data;
    end
  end

  assign cur_valid = byte_lock_q ? byte_vld_q : i_tx_valid;
  assign cur_data  = byte_lock_q ? byte_q : i_tx_data;

  // Pop after the last bit only when a real byte went out
  assign o_tx_pop = i_fall_en && (state_q == TX) && last_bit && cur_valid;

  //////////////////////////////////////////////////////////////////////
  // Bus outputs
  //////////////////////////////////////////////////////////////////////
  assign o_state = state_q;
  assign o_csn   = (state_q == IDLE) || (state_q == START_D) || (state_q == STOP_D);
  assign o_sck   = i_sck_level && ((state_q == TX) || (state_q == WAIT) || (state_q == RX));

  // MSB first with zeros when the FIFO ran dry
  assign o_copi  = (state_q == TX) && cur_valid && cur_data[3'd7 - cnt_q[2:0]];

endmodule : spi_bus_sequencer

// ==== src/spi_rx_deserializer.sv ====
//////////////////////////////////////////////////////////////////////
// CIPO shift register, MSB-first bytes pushed into the RX FIFO
//////////////////////////////////////////////////////////////////////
module spi_rx_deserializer (
  input  logic                i_ext_spi_clk_x,
  input  logic                i_srst,
  input  logic                i_rise_en,
  input  spi_pkg::spi_state_t i_state,
  input  logic                i_cipo,
  output logic                o_push,   // One cycle, byte complete
  output spi_pkg::byte_t      o_byte
);
  import spi_pkg::*;

  localparam int IDX_W = $clog2(BYTE_W);

  logic [IDX_W-1:0] bit_cnt_q;          // Samples taken in current byte
  byte_t            shift_q;
  logic             push_q;
  logic             sample;

  assign sample = i_rise_en && (i_state == RX);  // Mode 0 samples on rising SCK

  // Bit counter restarts outside RX
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      bit_cnt_q <= '0;
      push_q    <= 1'b0;
    end else begin
      push_q <= 1'b0;
      if (i_state != RX) begin
        bit_cnt_q <= '0;
      end else if (sample) begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
        push_q    <= (bit_cnt_q == IDX_W'(BYTE_W - 1));  // Eighth sample
      end
    end
  end

  always_ff @(posedge i_ext_spi_clk_x) begin
    if (sample) begin
      shift_q <= {shift_q[BYTE_W-2:0], i_cipo};  // First bit ends up as MSB
    end
  end

  assign o_push = push_q;
  assign o_byte = shift_q;

endmodule : spi_rx_deserializer

// ==== src/spi_generic_master.sv ====
//////////////////////////////////////////////////////////////////////
// SPI Mode 0 master top: byte FIFOs, phase enables, command capture,
// frame sequencer and RX deserializer
//////////////////////////////////////////////////////////////////////
module spi_generic_master #(
  parameter int CLK_RATIO  = 8,         // System clocks per SCK period
  parameter int FIFO_DEPTH = 16         // Entries in each byte FIFO
) (
  input  logic              i_ext_spi_clk_x,
  input  logic              i_srst,
  // Command
  input  logic              i_cmd_valid,
  input  spi_pkg::spi_cmd_t i_cmd,
  output logic              o_cmd_ready,
  // TX bytes
  input  logic              i_tx_valid,
  input  spi_pkg::byte_t    i_tx_data,
  output logic              o_tx_ready,
  // RX bytes
  output logic              o_rx_valid,
  output spi_pkg::byte_t    o_rx_data,
  input  logic              i_rx_ready,
  // SPI bus
  output logic              o_sck,
  output logic              o_csn,
  output logic              o_copi,
  input  logic              i_cipo,
  output logic              o_spi_idle
);
  import spi_pkg::*;

  logic       rise_en;
  logic       fall_en;
  logic       sck_level;
  logic       seq_valid;
  spi_cmd_t   seq_cmd;
  logic       seq_ready;
  logic       tx_head_valid;
  byte_t      tx_head_data;
  logic       tx_pop;
  spi_state_t seq_state;
  logic       rx_push;
  byte_t      rx_byte;

  ////////////////////////////////////////////////////////////////////
  // Byte FIFOs
  ////////////////////////////////////////////////////////////////////
  spi_byte_fifo #(.DEPTH(FIFO_DEPTH)) u_tx_fifo (
    .i_ext_spi_clk_x (i_ext_spi_clk_x),
    .i_srst          (i_srst),
    .i_wr_valid      (i_tx_valid),
    .i_wr_data       (i_tx_data),
    .o_wr_ready      (o_tx_ready),
    .i_rd_ready      (tx_pop),
    .o_rd_valid      (tx_head_valid),
    .o_rd_data       (tx_head_data)
  );

  // Full RX FIFO drops the byte, the bus keeps running
  spi_byte_fifo #(.DEPTH(FIFO_DEPTH)) u_rx_fifo (
    .i_ext_spi_clk_x (i_ext_spi_clk_x),
    .i_srst          (i_srst),
    .i_wr_valid      (rx_push),
    .i_wr_data       (rx_byte),
    .o_wr_ready      (),
    .i_rd_ready      (i_rx_ready),
    .o_rd_valid      (o_rx_valid),
    .o_rd_data       (o_rx_data)
  );

  spi_phase_gen #(.RATIO(CLK_RATIO)) u_phase_gen (
    .i_ext_spi_clk_x (i_ext_spi_clk_x),
    .i_srst          (i_srst),
    .o_rise_en       (rise_en),
    .o_fall_en       (fall_en),
    .o_sck_level     (sck_level)
  );

  spi_cmd_capture u_cmd_capture (
    .i_ext_spi_clk_x (i_ext_spi_clk_x),
    .i_srst          (i_srst),
    .i_cmd_valid     (i_cmd_valid),
    .i_cmd           (i_cmd),
    .o_cmd_ready     (o_cmd_ready),
    .i_seq_ready     (seq_ready),
    .o_seq_valid     (seq_valid),
    .o_seq_cmd       (seq_cmd)
  );

  spi_bus_sequencer u_bus_sequencer (
    .i_ext_spi_clk_x (i_ext_spi_clk_x),
    .i_srst          (i_srst),
    .i_rise_en       (rise_en),
    .i_fall_en       (fall_en),
    .i_sck_level     (sck_level),
    .i_cmd_valid     (seq_valid),
    .i_cmd           (seq_cmd),
    .o_cmd_ready     (seq_ready),
    .i_tx_valid      (tx_head_valid),
    .i_tx_data       (tx_head_data),
    .o_tx_pop        (tx_pop),
    .o_state         (seq_state),
    .o_sck           (o_sck),
    .o_csn           (o_csn),
    .o_copi          (o_copi)
  );

  spi_rx_deserializer u_rx_deserializer (
    .i_ext_spi_clk_x (i_ext_spi_clk_x),
    .i_srst          (i_srst),
    .i_rise_en       (rise_en),
    .i_state         (seq_state),
    .i_cipo          (i_cipo),
    .o_push          (rx_push),
    .o_byte          (rx_byte)
  );

  // Idle once no frame runs and no command waits in capture
  assign o_spi_idle = (seq_state == IDLE) && o_cmd_ready;

endmodule : spi_generic_master

// ==== dv/spi_protocol_checker.sv ====
//////////////////////////////////////////////////////////////////////
// SPI bus and command handshake assertions bound into the top level
//////////////////////////////////////////////////////////////////////
module spi_protocol_checker (
  input logic i_ext_spi_clk_x,
  input logic i_srst,
  input logic i_sck,
  input logic i_csn,
  input logic i_copi,
  input logic i_cmd_valid,
  input logic i_cmd_ready,
  input logic i_seq_ready             // Sequencer takes the held command
);

  // Deselected bus never clocks
  a_sck_idle: assert property (@(posedge i_ext_spi_clk_x) disable iff (i_srst)
    i_csn |-> !i_sck)
    else $error("SCK high while CSn is high");

  // Mode 0 slave samples while SCK is high
  a_copi_stable: assert property (@(posedge i_ext_spi_clk_x) disable iff (i_srst)
    (i_sck && $past(i_sck)) |-> $stable(i_copi))
    else $error("COPI changed while SCK was high");

  // Accepted or still held command keeps ready low until the sequencer takes it
  a_cmd_block: assert property (@(posedge i_ext_spi_clk_x) disable iff (i_srst)
    ((i_cmd_valid && i_cmd_ready) || (!i_cmd_ready && !i_seq_ready)) |=> !i_cmd_ready)
    else $error("Command ready while capture is full");

endmodule : spi_protocol_checker

bind spi_generic_master spi_protocol_checker u_protocol_checker (
  .i_ext_spi_clk_x (i_ext_spi_clk_x),
  .i_srst          (i_srst),
  .i_sck           (o_sck),
  .i_csn           (o_csn),
  .i_copi          (o_copi),
  .i_cmd_valid     (i_cmd_valid),
  .i_cmd_ready     (o_cmd_ready),
  .i_seq_ready     (seq_ready)
);

// ==== dv/tb_spi_generic_master.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench with random frames, SPI slave model and TX, RX and SCK scoreboard
//////////////////////////////////////////////////////////////////////
module tb_spi_generic_master;
  import spi_pkg::*;

  localparam int DEPTH   = 16;          // RX FIFO entries in the model
  localparam int TIMEOUT = 4000;        // Clocks allowed per wait

  logic     i_ext_spi_clk_x = 1'b0;
  logic     i_srst;
  logic     i_cmd_valid;
  spi_cmd_t i_cmd;
  logic     o_cmd_ready;
  logic     i_tx_valid;
  byte_t    i_tx_data;
  logic     o_tx_ready;
  logic     o_rx_valid;
  byte_t    o_rx_data;
  logic     i_rx_ready;
  logic     o_sck;
  logic     o_csn;
  logic     o_copi;
  logic     i_cipo = 1'b0;
  logic     o_spi_idle;

  logic [31:0] rng_q;
  byte_t       tx_exp[$];               // Bytes written this frame
  byte_t       tx_got[$];               // Bytes the slave saw on COPI
  byte_t       rx_sent[$];              // Bytes the slave drives this frame
  byte_t       rx_model[$];             // Expected RX FIFO contents
  int          frm_tx_bits;
  int          frm_pre_bits;            // Rises before the first RX bit
  int          frm_rx_bits;
  int          rise_cnt = 0;            // SCK rises with CSn low
  int          slv_idx;
  byte_t       slv_byte;
  byte_t       copi_sr;
  logic        sck_prev = 1'b0;
  logic        csn_prev = 1'b1;

  spi_generic_master #(.CLK_RATIO(8), .FIFO_DEPTH(DEPTH)) u_spi_generic_master (.*);

  always #10 i_ext_spi_clk_x = ~i_ext_spi_clk_x;

  //////////////////////////////////////////////////////////////////////
  // Slave model sampling bus edges between system clock edges
  //////////////////////////////////////////////////////////////////////
  always @(negedge i_ext_spi_clk_x) begin
    if (csn_prev && !o_csn) rise_cnt = 0;   // New frame
    if (!o_csn && o_sck && !sck_prev) begin
      if (rise_cnt < frm_tx_bits) begin
        copi_sr = {copi_sr[6:0], o_copi};   // MSB arrives first
        if (rise_cnt % 8 == 7) tx_got.push_back(copi_sr);
      end
      rise_cnt++;
    end
    // Next RX bit goes out after each SCK fall
    if (!o_csn && !o_sck && sck_prev && (rise_cnt >= frm_pre_bits)) begin
      slv_idx = rise_cnt - frm_pre_bits;
      if (slv_idx < frm_rx_bits) begin
        slv_byte = rx_sent[slv_idx / 8] << (slv_idx % 8);
        i_cipo   = slv_byte[7];
      end
    end
    sck_prev = o_sck;
    csn_prev = o_csn;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int rand_below(input int n);
    rng_q = xorshift32(rng_q);
    return int'(rng_q % 32'(n));
  endfunction

  task automatic check_value(input string name, input int expected, input int actual);
    if (expected != actual) begin
      $display("Mismatch %s expected %0h actual %0h", name, expected, actual);
      $display("*** TEST FAILED ***");
      $fatal(1, "Check %s failed", name);
    end
  endtask

  // One clock of a bounded wait
  task automatic step_clock(inout int waited, input string what);
    @(negedge i_ext_spi_clk_x);
    waited++;
    if (waited > TIMEOUT) begin
      $display("Timeout while waiting for %s", what);
      $display("*** TEST FAILED ***");
      $fatal(1, "Wait exceeded %0d clocks", TIMEOUT);
    end
  endtask

  task automatic write_tx(input byte_t data);
    int t;
    t           = 0;
    i_tx_valid  = 1'b1;
    i_tx_data   = data;
    while (!o_tx_ready) step_clock(t, "TX FIFO space");
    @(negedge i_ext_spi_clk_x);         // Transfer on the posedge between
    i_tx_valid = 1'b0;
    tx_exp.push_back(data);
  endtask

  task automatic read_rx(input byte_t expected);
    int t;
    t = 0;
    while (!o_rx_valid) step_clock(t, "an RX byte");
    check_value("rx byte", int'(expected), int'(o_rx_data));
    i_rx_ready = 1'b1;
    @(negedge i_ext_spi_clk_x);
    i_rx_ready = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // One command from start to idle with TX and SCK checks
  //////////////////////////////////////////////////////////////////////
  task automatic run_frame(input int tx_len, input int wait_cyc, input int rx_len);
    int t;
    t = 0;
    tx_exp.delete();
    tx_got.delete();
    rx_sent.delete();
    for (int i = 0; i < tx_len; i++) write_tx(byte_t'(rand_below(256)));
    for (int i = 0; i < rx_len; i++) rx_sent.push_back(byte_t'(rand_below(256)));
    frm_tx_bits  = 8 * tx_len;
    frm_pre_bits = 8 * tx_len + wait_cyc;
    frm_rx_bits  = 8 * rx_len;
    i_cmd.tx_len   = TX_LEN_W'(tx_len);
    i_cmd.wait_cyc = WAIT_W'(wait_cyc);
    i_cmd.rx_len   = RX_LEN_W'(rx_len);
    i_cmd_valid    = 1'b1;
    while (!o_cmd_ready) step_clock(t, "command ready");
    @(negedge i_ext_spi_clk_x);
    i_cmd_valid = 1'b0;
    while (!o_spi_idle) step_clock(t, "end of frame");
    check_value("tx byte count", tx_len, tx_got.size());
    foreach (tx_exp[i]) check_value("copi byte", int'(tx_exp[i]), int'(tx_got[i]));
    check_value("sck rises", 8 * (tx_len + rx_len) + wait_cyc, rise_cnt);
    foreach (rx_sent[i]) begin
      if (rx_model.size() < DEPTH) rx_model.push_back(rx_sent[i]);  // Full FIFO drops
    end
  endtask

  task automatic drain_rx();
    while (rx_model.size() > 0) read_rx(rx_model.pop_front());
  endtask

  initial begin
    i_srst      = 1'b1;
    i_cmd_valid = 1'b0;
    i_cmd       = '0;
    i_tx_valid  = 1'b0;
    i_tx_data   = '0;
    i_rx_ready  = 1'b0;
    rng_q       = 32'd34;
    repeat (2) @(negedge i_ext_spi_clk_x);
    i_srst = 1'b0;

    // Reset state
    check_value("reset csn", 1, int'(o_csn));
    check_value("reset sck", 0, int'(o_sck));
    check_value("reset cmd_ready", 1, int'(o_cmd_ready));
    check_value("reset tx_ready", 1, int'(o_tx_ready));
    check_value("reset spi_idle", 1, int'(o_spi_idle));
    check_value("reset rx_valid", 0, int'(o_rx_valid));

    // Random frames with RX drained after each
    for (int n = 0; n < 30; n++) begin
      run_frame(rand_below(15) + 1, rand_below(4), rand_below(16));
      drain_rx();
    end

    // 20 RX bytes into a 16 deep FIFO with no reader
    run_frame(1, 0, 10);
    run_frame(1, 0, 10);
    drain_rx();
    check_value("rx empty after drain", 0, int'(o_rx_valid));
    check_value("idle after overflow", 1, int'(o_spi_idle));

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule : tb_spi_generic_master

// ==== spi_generic_master.f ====
src/spi_pkg.sv
src/spi_phase_gen.sv
src/spi_byte_fifo.sv
src/spi_cmd_capture.sv
src/spi_bus_sequencer.sv
src/spi_rx_deserializer.sv
src/spi_generic_master.sv
dv/spi_protocol_checker.sv
dv/tb_spi_generic_master.sv

// ==== Makefile ====
# Verilator run of the SPI master testbench
TOP := tb_spi_generic_master

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f spi_generic_master.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	@if grep -q "\*\*\* TEST FAILED \*\*\*" sim.log; then echo "Simulation reported failure"; exit 1; fi
	@grep -q "TEST PASSED" sim.log || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
